/* mic_meter_params.svh */
// sizes and rates shared by the microphone level meter
// include this wherever a clock rate, frame size or LED count is needed

`ifndef MIC_METER_PARAMS_SVH
`define MIC_METER_PARAMS_SVH

// --------------------
// clocking
`define CLK_MHZ            50
`define MIC_SCK_HALF       8      // clk cycles per sck half period, 3.125 MHz

// --------------------
// I2S framing
`define MIC_FRAME_BITS     64     // sck periods per ws frame, 32 per channel
`define MIC_SAMPLE_BITS    24

// --------------------
// meter
`define METER_LEDS         8
`define METER_TICK_CYCLES  (`CLK_MHZ * 1000000)  // one tick per second

`endif

/* mic_meter_pkg.sv */
// types shared between the I2S receiver, the level meter and the top
// modules pull these in with a wildcard import

`include "mic_meter_params.svh"

package mic_meter_pkg;

    // two's complement sample as shifted out by the microphone
    typedef logic signed [`MIC_SAMPLE_BITS - 1:0] mic_sample_t;

    // absolute value, still fits 2**23
    typedef logic [`MIC_SAMPLE_BITS - 1:0] magnitude_t;

    // thermometer bar, bit 0 is the lowest LED
    typedef logic [`METER_LEDS - 1:0] led_bar_t;

    // sck position within one ws frame
    typedef logic [$clog2(`MIC_FRAME_BITS) - 1:0] bit_count_t;

    typedef enum logic [1:0]
    {
        RX_SYNC,   // waiting for the first ws fall
        RX_SHIFT,  // collecting the 24 sample bits
        RX_WAIT    // idle until the next left frame
    } rx_state_t;

endpackage

/* mic_i2s_receiver.sv */
// I2S master for an INMP441 microphone, left channel only
// generates sck and ws, pulses sample_valid once per frame with the new sample

`include "mic_meter_params.svh"

module mic_i2s_receiver
    import mic_meter_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample,
    output logic        sample_valid
);

    localparam int                half_w          = $clog2(`MIC_SCK_HALF);
    localparam logic [half_w-1:0] half_last       = half_w'(`MIC_SCK_HALF - 1);
    localparam bit_count_t        frame_last      = bit_count_t'(`MIC_FRAME_BITS - 1);
    localparam bit_count_t        half_frame_last = bit_count_t'(`MIC_FRAME_BITS / 2 - 1);
    localparam bit_count_t        sample_last     = bit_count_t'(`MIC_SAMPLE_BITS);

    logic [half_w-1:0] half_cnt;
    bit_count_t        bit_cnt;     // advances on each sck fall
    rx_state_t         state;
    mic_sample_t       shreg;
    logic              shift_done;  // bit 0 just landed in shreg
    logic              sck_rise;
    logic              sck_fall;
    logic              frame_start;

    // --------------------
    // sck divider

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            half_cnt <= '0;
            sck      <= 1'b0;
        end
        else if (half_cnt == half_last)
        begin
            half_cnt <= '0;
            sck      <= ~sck;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    assign sck_rise    = (half_cnt == half_last) && !sck;
    assign sck_fall    = (half_cnt == half_last) &&  sck;
    assign frame_start = sck_fall && (bit_cnt == frame_last);  // ws about to fall

    // --------------------
    // frame position and ws

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bit_cnt <= bit_count_t'(`MIC_FRAME_BITS / 2);  // start in the right half
            ws      <= 1'b1;
        end
        else if (sck_fall)
        begin
            bit_cnt <= (bit_cnt == frame_last) ? '0 : bit_cnt + 1'b1;
            if (bit_cnt == frame_last)
                ws <= 1'b0;                                // left channel begins
            else if (bit_cnt == half_frame_last)
                ws <= 1'b1;
        end
    end

    // --------------------
    // capture FSM, msb is sampled on the second rising sck of the frame

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= RX_SYNC;
            shift_done <= 1'b0;
        end
        else
        begin
            shift_done <= 1'b0;
            case (state)
                RX_SYNC:  if (frame_start) state <= RX_SHIFT;
                RX_WAIT:  if (frame_start) state <= RX_SHIFT;
                RX_SHIFT:
                begin
                    if (sck_rise && bit_cnt == sample_last)
                    begin
                        state      <= RX_WAIT;
                        shift_done <= 1'b1;
                    end
                end
                default:  state <= RX_SYNC;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_SHIFT && sck_rise && bit_cnt != '0)
            shreg <= {shreg[`MIC_SAMPLE_BITS - 2:0], sd};
        if (shift_done)
            sample <= shreg;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= shift_done;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid);

    a_ws_on_sck_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(sck));

endmodule

/* tick_gen.sv */
// periodic strobe, one clk wide, every tick_period clocks
// stands in for the slow clock of the lab board

`include "mic_meter_params.svh"

module tick_gen
#(
    parameter int tick_period = `METER_TICK_CYCLES
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int cnt_w = $clog2(tick_period + 1);

    localparam logic [cnt_w-1:0] reload = cnt_w'(tick_period - 1);

    logic [cnt_w-1:0] cnt;  // clocks left until the next tick

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt  <= reload;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= reload;
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // a period of 1 keeps tick high on purpose
    if (tick_period > 1)
    begin : g_tick_check
        a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
            tick |=> !tick);
    end

endmodule

/* level_meter.sv */
// peak hold per tick window plus an LED bar of the held peak
// peak, peak_valid and led update one clk after tick

`include "mic_meter_params.svh"

module level_meter
    import mic_meter_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mic_sample_t sample,
    input  logic        sample_valid,
    input  logic        tick,
    output magnitude_t  peak,
    output logic        peak_valid,
    output led_bar_t    led
);

    // LED 0 lights once the peak reaches 2**16
    localparam int led_base = `MIC_SAMPLE_BITS - `METER_LEDS;

    magnitude_t mag;
    magnitude_t run_max;  // maximum so far in the open window
    magnitude_t win_max;  // run_max including this cycle's sample

    // --------------------
    // bar encoding

    // LED i is lit when the top set bit is at least led_base + i
    function automatic led_bar_t led_encode(input magnitude_t level);
        led_bar_t bar;
        for (int i = 0; i < `METER_LEDS; i++)
        begin
            bar[i] = (level >> (led_base + i)) != '0;
        end
        return bar;
    endfunction

    // --------------------
    // magnitude and running maximum

    always_comb
    begin
        // -2**23 negates to itself, which reads as 2**23 unsigned
        if (sample[`MIC_SAMPLE_BITS - 1])
            mag = magnitude_t'(-sample);
        else
            mag = magnitude_t'(sample);

        if (sample_valid && mag > run_max)
            win_max = mag;
        else
            win_max = run_max;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run_max    <= '0;
            peak       <= '0;
            peak_valid <= 1'b0;
            led        <= '0;
        end
        else
        begin
            peak_valid <= tick;
            if (tick)
            begin
                peak    <= win_max;            // same-cycle sample belongs here
                led     <= led_encode(win_max);
                run_max <= '0;                 // next window starts empty
            end
            else
            begin
                run_max <= win_max;
            end
        end
    end

    // bar must look like 0..01..1
    a_led_thermometer: assert property (@(posedge clk) disable iff (!rst_n)
        (led & led_bar_t'(led + 1'b1)) == '0);

endmodule

/* mic_meter_top.sv */
// microphone level meter: INMP441 receiver, tick generator and peak meter
// lr is tied low so the microphone answers in the left slot

`include "mic_meter_params.svh"

module mic_meter_top
    import mic_meter_pkg::*;
#(
    parameter int tick_period = `METER_TICK_CYCLES
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output logic        lr,
    output mic_sample_t mic_sample,
    output logic        mic_valid,
    output magnitude_t  peak,
    output logic        peak_valid,
    output led_bar_t    led
);

    logic tick;

    assign lr = 1'b0;  // left channel

    mic_i2s_receiver i_receiver
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .sd           ( sd         ),
        .sck          ( sck        ),
        .ws           ( ws         ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  )
    );

    tick_gen # (.tick_period (tick_period))
    i_tick_gen
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .tick         ( tick       )
    );

    level_meter i_meter
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  ),
        .tick         ( tick       ),
        .peak         ( peak       ),
        .peak_valid   ( peak_valid ),
        .led          ( led        )
    );

endmodule

/* tb_mic_model.sv */
// behavioral INMP441, answers in the left slot only
// drives sd after each falling sck and reports every sample once it is fully sent

module tb_mic_model
    import mic_meter_pkg::*;
(
    input  logic        sck,
    input  logic        ws,
    output logic        sd,
    output mic_sample_t sent_sample,
    output logic        sent
);

    timeunit 1ns;
    timeprecision 100ps;

    int          seed;
    int          frame_no;
    int          bits_left;  // sample bits still to drive
    int          shift;
    logic        ws_last;
    mic_sample_t word;       // shifts left, msb goes out first
    mic_sample_t drawn;

    initial
    begin
        seed        = 32'hf73f21e4;
        frame_no    = 0;
        bits_left   = 0;
        ws_last     = 1'b1;
        word        = '0;
        drawn       = '0;
        sd          = 1'b0;
        sent        = 1'b0;
        sent_sample = '0;
    end

    always @(negedge sck)
    begin
        #1;  // let ws settle, it moves on the same clk edge
        if (bits_left > 0)
        begin
            sd        = word[`MIC_SAMPLE_BITS - 1];
            word      = word << 1;
            bits_left = bits_left - 1;
            if (bits_left == 0)
            begin
                sent_sample = drawn;
                sent        = 1'b1;
            end
        end
        else
        begin
            sd = 1'b0;  // rest of the slot and the right slot
        end

        // ws fall, the msb goes out on the next falling sck
        if (ws_last === 1'b1 && ws === 1'b0)
        begin
            frame_no  = frame_no + 1;
            drawn     = mic_sample_t'($random(seed));
            shift     = $unsigned($random(seed)) % 11;
            drawn     = drawn >>> shift;  // vary the level
            if (frame_no == 5)
                drawn = {1'b1, 23'd0};    // full scale negative
            word      = drawn;
            bits_left = `MIC_SAMPLE_BITS;
        end
        ws_last = ws;
        #1 sent = 1'b0;
    end

endmodule

/* tb_mic_meter.sv */
// testbench for the microphone level meter, built from flist.f
// a microphone model sends random samples, a checker compares samples, peaks and the LED bar

`include "mic_meter_params.svh"

module tb_mic_meter
    import mic_meter_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 905 + 7 * 1024, so the 8th sample lands on the first tick cycle
    localparam int tick_period = 8073;
    localparam int windows     = 12;
    localparam int watchdog_ns = windows * tick_period * 10 + 20_000;

    logic        clk;
    logic        rst_n;
    logic        sd;
    logic        sck;
    logic        ws;
    logic        lr;
    mic_sample_t mic_sample;
    logic        mic_valid;
    magnitude_t  peak;
    logic        peak_valid;
    led_bar_t    led;
    mic_sample_t sent_sample;
    logic        sent;

    mic_sample_t sample_q[$];     // sent by the model, not yet seen on mic_valid
    mic_sample_t exp_sample;
    magnitude_t  exp_max = '0;    // expected maximum of the open window
    logic        valid_last = 1'b0;
    int          peaks_seen = 0;
    int          boundary_hits = 0;
    int          neg_seen = 0;
    int          pos_seen = 0;
    bit          full_scale_seen = 1'b0;
    int          sck_clks = 0;    // clk cycles since sck last toggled
    int          sck_falls = 0;   // sck falls since ws last toggled
    logic        sck_last = 1'b0;
    logic        ws_last = 1'b1;

    mic_meter_top #(.tick_period (tick_period)) dut0
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sd         ( sd         ),
        .sck        ( sck        ),
        .ws         ( ws         ),
        .lr         ( lr         ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  ),
        .peak       ( peak       ),
        .peak_valid ( peak_valid ),
        .led        ( led        )
    );

    tb_mic_model mic0
    (
        .sck         ( sck         ),
        .ws          ( ws          ),
        .sd          ( sd          ),
        .sent_sample ( sent_sample ),
        .sent        ( sent        )
    );

    // --------------------
    // reference model

    function automatic magnitude_t ref_magnitude(input mic_sample_t s);
        int v;
        v = int'(s);
        if (v < 0)
            v = -v;  // full scale gives 2**23, still fits
        return magnitude_t'(v);
    endfunction

    function automatic led_bar_t ref_led(input magnitude_t level);
        int top;
        int lit;
        top = -1;
        for (int b = 0; b < `MIC_SAMPLE_BITS; b++)
        begin
            if ((level >> b) != '0)
                top = b;
        end
        lit = top - 15;  // nothing below 2**16
        if (lit < 0)
            lit = 0;
        if (lit > `METER_LEDS)
            lit = `METER_LEDS;
        return led_bar_t'((1 << lit) - 1);
    endfunction

    // --------------------
    // compare tasks

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sample(input mic_sample_t got, input mic_sample_t exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: mic_sample %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_peak(input magnitude_t got, input magnitude_t exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: peak %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_led(input led_bar_t got, input led_bar_t exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: led %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    // --------------------
    // clock, reset and stimulus

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    always @(posedge sent)
        sample_q.push_back(sent_sample);

    // --------------------
    // checker, samples between the clock edges

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (lr !== 1'b0)
            begin
                $display("lr is not held low at %0t ns", $time);
                abort_run();
            end

            // sck half period and ws framing seen by the microphone
            if (sck !== sck_last)
            begin
                if (sck_clks != `MIC_SCK_HALF)
                begin
                    $display("sck toggled after %0d clk cycles at %0t ns", sck_clks, $time);
                    abort_run();
                end
                sck_clks = 0;
                if (sck === 1'b0)
                    sck_falls++;
            end
            sck_clks++;
            if (ws !== ws_last)
            begin
                if (!(sck_last === 1'b1 && sck === 1'b0) || sck_falls != `MIC_FRAME_BITS / 2)
                begin
                    $display("ws changed off the frame timing at %0t ns", $time);
                    abort_run();
                end
                sck_falls = 0;
            end
            sck_last = sck;
            ws_last  = ws;

            if (sample_q.size() > 1)
            begin
                $display("a sent sample never showed up on mic_valid");
                abort_run();
            end

            // a sample on this cycle already belongs to the next window
            if (peak_valid)
            begin
                if (valid_last)
                    boundary_hits++;
                check_peak(peak, exp_max);
                check_led(led, ref_led(exp_max));
                peaks_seen++;
                exp_max = '0;
            end
            else if (peaks_seen == 0)
            begin
                check_peak(peak, '0);
                check_led(led, '0);
            end

            if (mic_valid)
            begin
                if (sample_q.size() == 0)
                begin
                    $display("mic_valid at %0t ns without a sample from the microphone", $time);
                    abort_run();
                end
                else
                begin
                    exp_sample = sample_q.pop_front();
                    check_sample(mic_sample, exp_sample);
                    if (ref_magnitude(exp_sample) > exp_max)
                        exp_max = ref_magnitude(exp_sample);
                    if (exp_sample[`MIC_SAMPLE_BITS - 1])
                        neg_seen++;
                    else if (exp_sample != '0)
                        pos_seen++;
                    if (exp_sample == {1'b1, 23'd0})
                        full_scale_seen = 1'b1;
                end
            end
            valid_last = mic_valid;
        end
    end

    // --------------------
    // end of run and watchdog

    initial
    begin
        wait (peaks_seen == windows);
        #1;
        if (boundary_hits == 0)
        begin
            $display("no sample ever arrived in the last cycle of a window");
            abort_run();
        end
        else if (!full_scale_seen || neg_seen == 0 || pos_seen == 0)
        begin
            $display("samples of both signs and full scale were not all captured");
            abort_run();
        end
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("timed out after %0d ns with %0d of %0d windows", watchdog_ns, peaks_seen,
            windows);
        abort_run();
    end

endmodule

/* flist.f */
+incdir+.
mic_meter_pkg.sv
mic_i2s_receiver.sv
tick_gen.sv
level_meter.sv
mic_meter_top.sv
tb_mic_model.sv
tb_mic_meter.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and fail on the fail message in the log

cd "$(dirname "$0")" && rm -rf obj_dir sim.log \
    && verilator --binary --timing --assert --timescale 1ns/100ps \
        -f flist.f --top-module tb_mic_meter -o sim_mic_meter \
    && ./obj_dir/sim_mic_meter > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log

cat sim.log
! grep -q "Simulation failed" sim.log
